// File: flist.f
logic/eth_frame_pkg.sv
logic/eth_mon_pkg.sv
logic/eth_frame_parser.sv
logic/eth_crc_check.sv
logic/eth_payload_check.sv
logic/eth_monitor.sv
testbench/tb_clock.sv
testbench/eth_monitor_asserts.sv
testbench/eth_monitor_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module eth_monitor_tb -f flist.f -o eth_monitor_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/eth_monitor_sim > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

// File: testbench/eth_monitor_tb.sv
/*
 Testbench for the GMII transmit monitor. Sends random frames of
 three kinds (length, tagged, pause) with injected faults, and checks
 the decoded fields, payload bus and error flags at each frm_rcvd
 against a model built alongside every frame. Stops at the first error.
*/
module eth_monitor_tb;

   localparam int n_frames    = 60;
   localparam int cycle_limit = n_frames * 260;

   // what the monitor should report for one frame
   typedef struct packed {
      eth_frame_pkg::mac_addr_t   dst;
      eth_frame_pkg::mac_addr_t   src;
      eth_frame_pkg::field16_t    len_type;
      eth_frame_pkg::field16_t    vlan_ctl;
      eth_frame_pkg::field16_t    pquant;
      logic                       is_vlan;
      logic                       is_pause;
      logic                       aborted;
      eth_mon_pkg::frame_status_t st;
      eth_mon_pkg::frame_status_t mask;
      logic [15:0]                n_pay;
   } exp_frame_t;

   logic                       tx_clk_int;
   logic                       reset;
   eth_frame_pkg::octet_t      txd;
   logic                       tx_dv;
   logic                       tx_er;
   eth_mon_pkg::frame_info_t   info;
   eth_mon_pkg::frame_status_t status;
   eth_frame_pkg::octet_t      payload;
   logic                       payload_vld;
   logic                       frm_rcvd;

   exp_frame_t            exp_q[$];
   eth_frame_pkg::octet_t exp_pay[$];
   int                    rx_cnt = 0;
   int                    frames_done = 0;
   int                    cycles = 0;

   tb_clock u_clock (
      .clk(tx_clk_int)
   );

   eth_monitor #(
      .max_payload_len(1500)
   ) dut (
      .tx_clk_int (tx_clk_int),
      .reset      (reset),
      .txd        (txd),
      .tx_dv      (tx_dv),
      .tx_er      (tx_er),
      .info       (info),
      .status     (status),
      .payload    (payload),
      .payload_vld(payload_vld),
      .frm_rcvd   (frm_rcvd)
   );

   // ------------------------------------------------------------------
   // error reporting and compares
   // ------------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_mac(input string name, input eth_frame_pkg::mac_addr_t got,
                              input eth_frame_pkg::mac_addr_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic compare_field(input string name, input eth_frame_pkg::field16_t got,
                                input eth_frame_pkg::field16_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic compare_octet(input string name, input eth_frame_pkg::octet_t got,
                                input eth_frame_pkg::octet_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
   endtask

   // only bits set in mask are compared
   task automatic compare_status(input eth_mon_pkg::frame_status_t got,
                                 input eth_mon_pkg::frame_status_t exp,
                                 input eth_mon_pkg::frame_status_t mask);
      if (((got ^ exp) & mask) !== '0)
         stop_on_error($sformatf("FAIL %0t status got %b expected %b (mask %b)",
                                 $time, got, exp, mask));
   endtask

   // ------------------------------------------------------------------
   // frame model
   // ------------------------------------------------------------------
   // serial CRC-32, data bits lsb first
   function automatic eth_frame_pkg::crc_t crc_step(input eth_frame_pkg::crc_t c,
                                                    input eth_frame_pkg::octet_t o);
      logic fb;
      for (int i = 0; i < 8; i++)
      begin
         fb = o[i] ^ c[31];
         c  = c << 1;
         if (fb)
            c = c ^ eth_frame_pkg::crc_poly;
      end
      return c;
   endfunction

   task automatic drive_octet(input eth_frame_pkg::octet_t o, input logic er);
      @(negedge tx_clk_int);
      txd   = o;
      tx_dv = 1'b1;
      tx_er = er;
   endtask

   task automatic drive_idle(input int n);
      repeat (n)
      begin
         @(negedge tx_clk_int);
         txd   = '0;
         tx_dv = 1'b0;
         tx_er = 1'b0;
      end
   endtask

   task automatic send_frame();
      eth_frame_pkg::octet_t    fr[$];
      eth_frame_pkg::octet_t    o;
      eth_frame_pkg::octet_t    incr;
      eth_frame_pkg::octet_t    val;
      eth_frame_pkg::crc_t      c;
      eth_frame_pkg::mac_addr_t d;
      eth_frame_pkg::mac_addr_t s;
      exp_frame_t               e;
      int                       kind;
      int                       fault;
      int                       plen;
      int                       flen;
      int                       err_idx;
      int                       drop_at;
      int                       n;
      int                       gap;
      kind  = $urandom % 3;
      fault = $urandom % 10;
      e      = '0;
      e.mask = '1;
      e.aborted = (fault == 4);
      d = eth_frame_pkg::mac_addr_t'({$urandom, $urandom});
      s = eth_frame_pkg::mac_addr_t'({$urandom, $urandom});
      if (kind == 2)
         d = eth_frame_pkg::pause_dst_addr;
      for (int i = 0; i < 6; i++)
         fr.push_back(d[8*i +: 8]);
      for (int i = 0; i < 6; i++)
         fr.push_back(s[8*i +: 8]);
      e.dst = d;
      e.src = s;
      // header by kind
      if (kind == 0)
      begin
         plen = (fault == 2) ? 48 + $urandom % 153 : 46 + $urandom % 155;
         flen = (fault == 2) ? plen - 1 : plen;
         e.st.len_err = (fault == 2);
         fr.push_back(8'(flen >> 8));
         fr.push_back(8'(flen));
      end
      else if (kind == 1)
      begin
         plen = 30 + $urandom % 171;
         flen = plen;
         e.is_vlan  = 1'b1;
         e.vlan_ctl = 16'($urandom);
         fr.push_back(8'h81);
         fr.push_back(8'h00);
         fr.push_back(e.vlan_ctl[15:8]);
         fr.push_back(e.vlan_ctl[7:0]);
         fr.push_back(8'(flen >> 8));
         fr.push_back(8'(flen));
      end
      else
      begin
         plen = 0;
         flen = int'(eth_frame_pkg::ethertype_pause);
         e.is_pause = 1'b1;
         e.pquant   = 16'($urandom);
         e.st.pause_op_err = (fault == 5);
         fr.push_back(8'h88);
         fr.push_back(8'h08);
         fr.push_back(8'h00);
         fr.push_back((fault == 5) ? 8'h02 : 8'h01);
         fr.push_back(e.pquant[15:8]);
         fr.push_back(e.pquant[7:0]);
      end
      e.len_type = 16'(flen);
      // counter pattern payload
      err_idx = (plen > 2) ? 2 + $urandom % (plen - 2) : 0;
      e.st.payload_err = (fault == 1) && (plen > 2);
      val  = 8'($urandom);
      incr = 8'($urandom);
      for (int k = 0; k < plen; k++)
      begin
         if (k == 0)
            o = val;
         else if (k == 1)
            o = incr;
         else
         begin
            val = val + incr;
            o   = val;
         end
         if (e.st.payload_err && k == err_idx)
            o = o ^ (8'h01 << ($urandom % 8));
         fr.push_back(o);
         if (k < flen && !e.aborted)
         begin
            exp_pay.push_back(o);
            e.n_pay = e.n_pay + 1'b1;
         end
      end
      while (fr.size() < eth_frame_pkg::min_frame_octets)
         fr.push_back(8'h00);
      // FCS is the complemented CRC, msb of the register first
      c = '1;
      foreach (fr[i])
         c = crc_step(c, fr[i]);
      for (int k = 0; k < 4; k++)
      begin
         for (int b = 0; b < 8; b++)
            o[b] = ~c[31 - (8 * k + b)];
         fr.push_back(o);
      end
      if (fault == 0)
      begin
         err_idx = fr.size() - 1 - $urandom % 4;
         fr[err_idx] ^= 8'h01 << ($urandom % 8);
         e.st.crc_err = 1'b1;
      end
      // short length field leaves crc and end flags to the parser
      if (e.st.len_err)
      begin
         e.mask.crc_err = 1'b0;
         e.mask.end_err = 1'b0;
      end
      e.st.mac_err = (fault == 3);
      err_idx = $urandom % (8 + fr.size());
      drop_at = 3 + $urandom % 19;
      if (e.aborted)
      begin
         e.st        = '0;
         e.st.frame_err = 1'b1;
         e.mask      = '0;
         e.mask.frame_err = 1'b1;
      end
      exp_q.push_back(e);
      n = e.aborted ? drop_at : 8 + fr.size();
      for (int i = 0; i < n; i++)
      begin
         if (i < 7)
            o = eth_frame_pkg::preamble_octet;
         else if (i == 7)
            o = eth_frame_pkg::sfd_octet;
         else
            o = fr[i - 8];
         drive_octet(o, (fault == 3) && (i == err_idx));
      end
      gap = 1 + $urandom % 12;
      if (e.aborted && gap < 3)
         gap = 3;
      drive_idle(gap);
   endtask

   // ------------------------------------------------------------------
   // response checking
   // ------------------------------------------------------------------
   task automatic check_frame();
      exp_frame_t e;
      if (exp_q.size() == 0)
         stop_on_error("frm_rcvd pulsed with no frame outstanding");
      else
      begin
         e = exp_q.pop_front();
         if (!e.aborted)
         begin
            compare_mac("info.dst", info.dst, e.dst);
            compare_mac("info.src", info.src, e.src);
            compare_field("info.len_type", info.len_type, e.len_type);
            compare_field("info.prmble_len", 16'(info.prmble_len), 16'd8);
            compare_flag("info.is_vlan", info.is_vlan, e.is_vlan);
            compare_flag("info.is_pause", info.is_pause, e.is_pause);
            if (e.is_vlan)
               compare_field("info.vlan_ctl", info.vlan_ctl, e.vlan_ctl);
            if (e.is_pause)
               compare_field("info.pquant", info.pquant, e.pquant);
            if (rx_cnt != int'(e.n_pay))
               stop_on_error($sformatf("payload bus carried %0d octets, %0d were sent",
                                       rx_cnt, e.n_pay));
         end
         compare_status(status, e.st, e.mask);
         rx_cnt = 0;
         frames_done++;
      end
   endtask

   // outputs only move on the rising edge
   always @(negedge tx_clk_int)
   begin
      if (!reset)
      begin
         if (payload_vld)
         begin
            if (exp_pay.size() == 0)
               stop_on_error("payload octet seen with none expected");
            else
               compare_octet("payload", payload, exp_pay.pop_front());
            rx_cnt++;
         end
         if (frm_rcvd)
            check_frame();
      end
   end

   always @(posedge tx_clk_int)
   begin
      cycles++;
      if (cycles >= cycle_limit)
         stop_on_error("timeout, not all frames were reported before the cycle limit");
   end

   initial
   begin
      void'($urandom(32'h93b59554));
      reset = 1'b1;
      txd   = '0;
      tx_dv = 1'b0;
      tx_er = 1'b0;
      repeat (5) @(negedge tx_clk_int);
      reset = 1'b0;
      drive_idle(4);
      repeat (n_frames) send_frame();
      while (frames_done < n_frames)
         @(negedge tx_clk_int);
      drive_idle(4);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: testbench/eth_monitor_asserts.sv
/*
 Concurrent assertions on the frame parser, bound into every
 eth_frame_parser instance. Covers the checker strobes during pause
 frames, the frm_rcvd pulse width and the state encoding.
*/
module eth_monitor_asserts (
   input logic                     tx_clk_int,
   input logic                     reset,
   input eth_mon_pkg::mon_state_e  state,
   input eth_mon_pkg::parse_ctl_t  ctl,
   input eth_mon_pkg::frame_info_t info,
   input logic                     frm_rcvd
);

   // pause frames carry no payload octets
   pause_no_data: assert property (@(posedge tx_clk_int) disable iff (reset)
      (info.is_pause && state != eth_mon_pkg::idle) |-> !(ctl.data_en && ctl.crc_en))
      else $error("data and crc strobes both high in pause frame");

   frm_rcvd_pulse: assert property (@(posedge tx_clk_int) disable iff (reset)
      frm_rcvd |=> !frm_rcvd)
      else $error("frm_rcvd longer than one cycle");

   state_legal: assert property (@(posedge tx_clk_int) disable iff (reset)
      4'(state) <= 4'(eth_mon_pkg::utype))
      else $error("parser state outside its encoding");

endmodule

bind eth_frame_parser eth_monitor_asserts u_asserts (
   .tx_clk_int(tx_clk_int),
   .reset     (reset),
   .state     (state),
   .ctl       (ctl),
   .info      (info),
   .frm_rcvd  (frm_rcvd)
);

// File: testbench/tb_clock.sv
/*
 Free-running testbench clock, period 10.
 Starts low and toggles every 5 time units.
*/
module tb_clock (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

endmodule

// File: logic/eth_monitor.sv
/*
 GMII transmit monitor top level. Connects the frame parser to the
 CRC and payload checkers and gathers all error flags into status.
 info and status are valid when frm_rcvd pulses.
*/
module eth_monitor #(
   parameter int max_payload_len = 1500
) (
   input  logic                       tx_clk_int,
   input  logic                       reset,
   input  eth_frame_pkg::octet_t      txd,
   input  logic                       tx_dv,
   input  logic                       tx_er,
   output eth_mon_pkg::frame_info_t   info,
   output eth_mon_pkg::frame_status_t status,
   output eth_frame_pkg::octet_t      payload,
   output logic                       payload_vld,
   output logic                       frm_rcvd
);

   eth_mon_pkg::parse_ctl_t ctl;
   logic crc_err;
   logic payload_err;
   logic prmbl_err;
   logic len_err;
   logic frame_err;
   logic pause_op_err;
   logic pause_dst_err;
   logic mac_err;
   logic end_err;

   eth_frame_parser #(
      .max_payload_len(max_payload_len)
   ) u_parser (
      .tx_clk_int   (tx_clk_int),
      .reset        (reset),
      .txd          (txd),
      .tx_dv        (tx_dv),
      .tx_er        (tx_er),
      .ctl          (ctl),
      .info         (info),
      .prmbl_err    (prmbl_err),
      .len_err      (len_err),
      .frame_err    (frame_err),
      .pause_op_err (pause_op_err),
      .pause_dst_err(pause_dst_err),
      .mac_err      (mac_err),
      .end_err      (end_err),
      .frm_rcvd     (frm_rcvd)
   );

   eth_crc_check u_crc (
      .tx_clk_int(tx_clk_int),
      .reset     (reset),
      .txd       (txd),
      .ctl       (ctl),
      .crc_err   (crc_err)
   );

   eth_payload_check u_payload (
      .tx_clk_int (tx_clk_int),
      .reset      (reset),
      .txd        (txd),
      .ctl        (ctl),
      .payload    (payload),
      .payload_vld(payload_vld),
      .payload_err(payload_err)
   );

   // checker flags beside the parser flags
   assign status = '{crc_err:       crc_err,
                     prmbl_err:     prmbl_err,
                     len_err:       len_err,
                     payload_err:   payload_err,
                     frame_err:     frame_err,
                     pause_op_err:  pause_op_err,
                     pause_dst_err: pause_dst_err,
                     mac_err:       mac_err,
                     end_err:       end_err};

endmodule

// File: logic/eth_payload_check.sv
/*
 Payload bus and pattern check. Payload octets appear on the bus one
 cycle after the wire. Octet 0 is the start value and octet 1 the
 increment; each later octet must equal the previous expected value
 plus the increment, modulo 256.
*/
module eth_payload_check (
   input  logic                    tx_clk_int,
   input  logic                    reset,
   input  eth_frame_pkg::octet_t   txd,
   input  eth_mon_pkg::parse_ctl_t ctl,
   output eth_frame_pkg::octet_t   payload,
   output logic                    payload_vld,
   output logic                    payload_err
);

   eth_frame_pkg::octet_t exp_q;
   eth_frame_pkg::octet_t incr_q;

   always_ff @(posedge tx_clk_int or posedge reset)
   begin
      if (reset)
      begin
         payload_vld <= 1'b0;
         payload_err <= 1'b0;
      end
      else
      begin
         payload_vld <= ctl.data_en;
         // also cleared at frame start for frames without payload
         if (ctl.dst_start || (ctl.data_en && ctl.data_idx == '0))
            payload_err <= 1'b0;
         else if (ctl.data_en && ctl.data_idx > 1 && txd != exp_q)
            payload_err <= 1'b1;
      end
   end

   always_ff @(posedge tx_clk_int)
   begin
      if (ctl.data_en)
      begin
         payload <= txd;
         if (ctl.data_idx == '0)
            exp_q <= txd;
         else if (ctl.data_idx == 1)
         begin
            incr_q <= txd;
            exp_q  <= exp_q + txd;
         end
         else
            exp_q <= exp_q + incr_q;
      end
   end

endmodule

// File: logic/eth_crc_check.sv
/*
 Running CRC-32 over the octets the parser marks as CRC span, from
 the first destination octet through the FCS. A good frame leaves
 the fixed residue, so crc_err is valid after the last FCS octet.
*/
module eth_crc_check (
   input  logic                    tx_clk_int,
   input  logic                    reset,
   input  eth_frame_pkg::octet_t   txd,
   input  eth_mon_pkg::parse_ctl_t ctl,
   output logic                    crc_err
);

   eth_frame_pkg::crc_t crc_q;
   eth_frame_pkg::crc_t crc_nxt;

   // eight serial steps per octet, lsb first
   always_comb
   begin
      crc_nxt = ctl.dst_start ? '1 : crc_q;
      for (int i = 0; i < 8; i++)
      begin
         if (txd[i] ^ crc_nxt[31])
            crc_nxt = (crc_nxt << 1) ^ eth_frame_pkg::crc_poly;
         else
            crc_nxt = crc_nxt << 1;
      end
   end

   always_ff @(posedge tx_clk_int)
   begin
      if (ctl.crc_en)
         crc_q <= crc_nxt;
   end

   always_ff @(posedge tx_clk_int or posedge reset)
   begin
      if (reset)
         crc_err <= 1'b0;
      else if (ctl.crc_en)
         crc_err <= (crc_nxt != eth_frame_pkg::crc_residue);
   end

endmodule

// File: logic/eth_frame_parser.sv
/*
 GMII transmit frame parser. Tracks each frame from the preamble to
 the FCS, captures the header fields and raises the framing and
 header error flags. The strobes on ctl tell the CRC and payload
 checkers which octets they take.
*/
module eth_frame_parser #(
   parameter int max_payload_len = 1500
) (
   input  logic                     tx_clk_int,
   input  logic                     reset,
   input  eth_frame_pkg::octet_t    txd,
   input  logic                     tx_dv,
   input  logic                     tx_er,
   output eth_mon_pkg::parse_ctl_t  ctl,
   output eth_mon_pkg::frame_info_t info,
   output logic                     prmbl_err,
   output logic                     len_err,
   output logic                     frame_err,
   output logic                     pause_op_err,
   output logic                     pause_dst_err,
   output logic                     mac_err,
   output logic                     end_err,
   output logic                     frm_rcvd
);

   eth_mon_pkg::mon_state_e state;
   eth_mon_pkg::mon_state_e state_nxt;
   eth_mon_pkg::mon_state_e last_state;
   eth_mon_pkg::pos_cnt_t   count;
   eth_mon_pkg::pos_cnt_t   count_nxt;
   eth_mon_pkg::pos_cnt_t   poscnt;
   eth_mon_pkg::pos_cnt_t   len_ovh;
   eth_frame_pkg::field16_t flen;
   logic                    last_tx_dv;
   logic                    sof;
   logic                    frm_end;
   logic                    len_chk;

   assign sof     = tx_dv & ~last_tx_dv;
   assign frm_end = (last_state != eth_mon_pkg::idle) && (state == eth_mon_pkg::idle);

   // full length/type value while its second octet is on txd
   assign flen = {info.len_type[15:8], txd};

   assign len_ovh = info.is_vlan ? eth_mon_pkg::pos_cnt_t'(eth_frame_pkg::vlan_hdr_octets)
                                 : eth_mon_pkg::pos_cnt_t'(eth_frame_pkg::hdr_octets);

   // length check only for plain length frames above the pad limit
   assign len_chk = frm_end && (last_state == eth_mon_pkg::crc) && !info.is_pause &&
                    ((!info.is_vlan && info.len_type > 45) || (info.is_vlan && info.len_type > 41));

   // ------------------------------------------------------------------
   // checker strobes
   // ------------------------------------------------------------------
   always_comb
   begin
      ctl.dst_start = (state == eth_mon_pkg::dst) && (last_state != eth_mon_pkg::dst);
      ctl.data_en   = (state == eth_mon_pkg::data);
      ctl.data_idx  = count;
      case (state)
         eth_mon_pkg::idle, eth_mon_pkg::prmbl, eth_mon_pkg::abort: ctl.crc_en = 1'b0;
         eth_mon_pkg::utype: ctl.crc_en = tx_dv;
         default: ctl.crc_en = 1'b1;
      endcase
   end

   // ------------------------------------------------------------------
   // frame state machine
   // ------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      count_nxt = (count == '1) ? count : count + 1'b1;
      // dv dropping inside a known frame is an abort
      if (!tx_dv && state != eth_mon_pkg::idle && state != eth_mon_pkg::abort &&
          state != eth_mon_pkg::utype)
      begin
         state_nxt = eth_mon_pkg::abort;
      end
      else
      begin
         case (state)
            eth_mon_pkg::idle:
               if (sof)
                  state_nxt = eth_mon_pkg::prmbl;
            eth_mon_pkg::prmbl:
               if (txd == eth_frame_pkg::sfd_octet)
                  state_nxt = eth_mon_pkg::dst;
            eth_mon_pkg::dst:
               if (count == 5)
                  state_nxt = eth_mon_pkg::src;
            eth_mon_pkg::src:
               if (count == 5)
                  state_nxt = eth_mon_pkg::typelen;
            eth_mon_pkg::typelen:
               if (count != '0)
               begin
                  if (flen <= max_payload_len)
                     state_nxt = (flen != '0) ? eth_mon_pkg::data : eth_mon_pkg::pad;
                  else if (flen == eth_frame_pkg::ethertype_pause)
                     state_nxt = eth_mon_pkg::pause;
                  else if (flen == eth_frame_pkg::ethertype_vlan)
                     state_nxt = eth_mon_pkg::tag;
                  else
                     state_nxt = eth_mon_pkg::utype;
               end
            eth_mon_pkg::pause:
               if (count == 3)
                  state_nxt = eth_mon_pkg::pad;
            eth_mon_pkg::tag:
               if (count == 1)
                  state_nxt = eth_mon_pkg::len;
            eth_mon_pkg::len:
               // a second tag lands here as a type and is not decoded
               if (count != '0)
               begin
                  if (flen > max_payload_len)
                     state_nxt = eth_mon_pkg::utype;
                  else
                     state_nxt = (flen != '0) ? eth_mon_pkg::data : eth_mon_pkg::pad;
               end
            eth_mon_pkg::data:
               if (count >= info.len_type - 1'b1)
                  state_nxt = (poscnt < eth_frame_pkg::min_frame_octets - 1) ?
                              eth_mon_pkg::pad : eth_mon_pkg::crc;
            eth_mon_pkg::pad:
               if (poscnt >= eth_frame_pkg::min_frame_octets - 1)
                  state_nxt = eth_mon_pkg::crc;
            eth_mon_pkg::crc:
               if (count == 3)
                  state_nxt = eth_mon_pkg::idle;
            eth_mon_pkg::abort, eth_mon_pkg::utype:
               if (!tx_dv)
                  state_nxt = eth_mon_pkg::idle;
            default:
               state_nxt = eth_mon_pkg::idle;
         endcase
      end
      // field counter restarts on every state change
      if (state_nxt != state)
         count_nxt = '0;
   end

   always_ff @(posedge tx_clk_int or posedge reset)
   begin
      if (reset)
      begin
         state      <= eth_mon_pkg::idle;
         last_state <= eth_mon_pkg::idle;
         count      <= '0;
         poscnt     <= '0;
         last_tx_dv <= 1'b0;
      end
      else
      begin
         state      <= state_nxt;
         last_state <= state;
         count      <= count_nxt;
         last_tx_dv <= tx_dv;
         if (ctl.dst_start)
            poscnt <= 16'd1;
         else if (poscnt != '1)
            poscnt <= poscnt + 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // field capture
   // ------------------------------------------------------------------
   always_ff @(posedge tx_clk_int or posedge reset)
   begin
      if (reset)
      begin
         info <= '0;
      end
      else
      begin
         if (sof)
         begin
            info.prmble_len <= 14'd1;
            info.is_pause   <= 1'b0;
         end
         else if (state == eth_mon_pkg::prmbl)
            info.prmble_len <= info.prmble_len + 1'b1;
         case (state)
            eth_mon_pkg::dst: info.dst[{count[2:0], 3'b000} +: 8] <= txd;
            eth_mon_pkg::src: info.src[{count[2:0], 3'b000} +: 8] <= txd;
            eth_mon_pkg::typelen, eth_mon_pkg::len:
            begin
               if (count == '0)
                  info.len_type[15:8] <= txd;
               else
                  info.len_type[7:0] <= txd;
               // tag info of the previous frame goes at the outer type
               if (state == eth_mon_pkg::typelen)
               begin
                  info.is_vlan  <= 1'b0;
                  info.vlan_ctl <= '0;
               end
            end
            eth_mon_pkg::tag:
            begin
               info.is_vlan <= 1'b1;
               if (count == '0)
                  info.vlan_ctl[15:8] <= txd;
               else
                  info.vlan_ctl[7:0] <= txd;
            end
            eth_mon_pkg::pause:
            begin
               info.is_pause <= 1'b1;
               // octets 0 and 1 are the opcode
               if (count == 2)
                  info.pquant[15:8] <= txd;
               else if (count == 3)
                  info.pquant[7:0] <= txd;
            end
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // error flags and end of frame
   // ------------------------------------------------------------------
   always_ff @(posedge tx_clk_int or posedge reset)
   begin
      if (reset)
      begin
         prmbl_err     <= 1'b0;
         len_err       <= 1'b0;
         frame_err     <= 1'b0;
         pause_op_err  <= 1'b0;
         pause_dst_err <= 1'b0;
         mac_err       <= 1'b0;
         end_err       <= 1'b0;
         frm_rcvd      <= 1'b0;
      end
      else
      begin
         frm_rcvd <= frm_end;
         if (sof)
         begin
            prmbl_err     <= (txd != eth_frame_pkg::preamble_octet);
            mac_err       <= tx_er;
            frame_err     <= 1'b0;
            end_err       <= 1'b0;
            pause_op_err  <= 1'b0;
            pause_dst_err <= 1'b0;
         end
         else
         begin
            if (state == eth_mon_pkg::prmbl && txd != eth_frame_pkg::preamble_octet &&
                txd != eth_frame_pkg::sfd_octet)
               prmbl_err <= 1'b1;
            if (state == eth_mon_pkg::abort)
               frame_err <= 1'b1;
            if (tx_er && tx_dv)
               mac_err <= 1'b1;
            // nothing more expected but dv still high
            if (frm_end && tx_dv)
               end_err <= 1'b1;
            if (state == eth_mon_pkg::pause)
            begin
               if ((count == 0 && txd != 8'h00) || (count == 1 && txd != 8'h01))
                  pause_op_err <= 1'b1;
               if (info.dst != eth_frame_pkg::pause_dst_addr)
                  pause_dst_err <= 1'b1;
            end
         end
         if (state == eth_mon_pkg::typelen)
            len_err <= 1'b0;
         else if (len_chk)
            len_err <= tx_dv || (info.len_type != poscnt - len_ovh);
      end
   end

endmodule

// File: logic/eth_mon_pkg.sv
/*
 Monitor-internal types. Parser state encoding, the control strobes
 the parser hands to the checkers, and the decoded field and error
 status records presented at the monitor outputs.
*/
package eth_mon_pkg;

   // parser states
   typedef enum logic [3:0] {
      idle,
      prmbl,
      dst,
      src,
      typelen,
      pause,
      tag,
      len,
      data,
      pad,
      crc,
      abort,
      utype
   } mon_state_e;

   // saturating octet counter
   typedef logic [15:0] pos_cnt_t;

   // strobes from the parser to the CRC and payload checkers
   typedef struct packed {
      logic     dst_start;
      logic     crc_en;
      logic     data_en;
      pos_cnt_t data_idx;
   } parse_ctl_t;

   // decoded header fields of the last frame
   typedef struct packed {
      eth_frame_pkg::mac_addr_t dst;
      eth_frame_pkg::mac_addr_t src;
      eth_frame_pkg::field16_t  len_type;
      eth_frame_pkg::field16_t  vlan_ctl;
      eth_frame_pkg::field16_t  pquant;
      logic [13:0]              prmble_len;
      logic                     is_vlan;
      logic                     is_pause;
   } frame_info_t;

   // per-frame error flags
   typedef struct packed {
      logic crc_err;
      logic prmbl_err;
      logic len_err;
      logic payload_err;
      logic frame_err;
      logic pause_op_err;
      logic pause_dst_err;
      logic mac_err;
      logic end_err;
   } frame_status_t;

endpackage

// File: logic/eth_frame_pkg.sv
/*
 Ethernet frame format definitions for the GMII transmit monitor.
 Field widths and the fixed octet, type and CRC values of a frame.
 Shared by the RTL and the testbench through scoped names.
*/
package eth_frame_pkg;

   // ------------------------------------------------------------------
   // field types
   // ------------------------------------------------------------------
   typedef logic [7:0]  octet_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [15:0] field16_t;
   typedef logic [31:0] crc_t;

   // ------------------------------------------------------------------
   // framing octets and ethertypes
   // ------------------------------------------------------------------
   localparam octet_t preamble_octet = 8'h55;
   localparam octet_t sfd_octet      = 8'hD5;

   localparam field16_t ethertype_vlan  = 16'h8100;
   localparam field16_t ethertype_pause = 16'h8808;

   // 01-80-c2-00-00-01, first octet on the wire in the low byte
   localparam mac_addr_t pause_dst_addr = 48'h01_00_00_C2_80_01;

   // frame length without FCS
   localparam int min_frame_octets = 60;

   // ------------------------------------------------------------------
   // CRC-32
   // ------------------------------------------------------------------
   localparam crc_t crc_poly    = 32'h04C11DB7;
   localparam crc_t crc_residue = 32'hC704DD7B;

   // header plus FCS overhead, untagged and tagged
   localparam int hdr_octets      = 18;
   localparam int vlan_hdr_octets = 22;

endpackage
